// ==== rtl/mem_pipe_pkg.sv ====
// memory pipeline shared definitions
// widths, memory depth and the opcode/state encodings used by both stages

`default_nettype none

package mem_pipe_pkg;

localparam int XLEN       = 32;                  // data and address width
localparam int REG_IDX_W  = 5;
localparam int DMEM_WORDS = 256;
localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word address width
localparam int BE_W       = XLEN / 8;            // byte lanes per word

typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
} mem_op_e;

typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
} mem_size_e;

// writeback value source
typedef enum logic [1:0] {
    RD_SRC_ALU = 2'd0,
    RD_SRC_CSR = 2'd1,
    RD_SRC_MEM = 2'd2
} rd_src_e;

typedef enum logic {
    ST_RUN  = 1'b0,
    ST_TRAP = 1'b1
} ctrl_state_e;

endpackage : mem_pipe_pkg

`default_nettype wire

// ==== rtl/mem_pipe_ctrl.sv ====
// memory pipeline hazard control
// trap FSM for misaligned accesses, global stall and per-stage squash

`timescale 1ns/100ps
`default_nettype none

module mem_pipe_ctrl
    import mem_pipe_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            wb_stall,
    input  wire logic            flush,
    input  wire logic            trap_ack,
    input  wire logic            m1_branch,
    input  wire logic            m1_misalign,
    input  wire logic [XLEN-1:0] m1_pc,
    output logic                 stall,
    output logic                 m1_flush,
    output logic                 m2_flush,
    output logic                 ready,
    output logic                 trap,
    output logic [XLEN-1:0]      trap_pc
);

ctrl_state_e state_q;
logic        take_trap;  // misaligned op leaving stage one

assign trap      = (state_q == ST_TRAP);
assign stall     = wb_stall || trap;  // trap freezes intake until acked
assign ready     = !stall;
assign take_trap = m1_misalign && !stall;

// squash only acts when the pipe moves, except for an explicit flush
assign m1_flush = flush || ((m1_branch || m1_misalign) && !stall);
assign m2_flush = flush || take_trap;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state_q <= ST_RUN;
    end else begin
        unique case (state_q)
            ST_RUN:  state_q <= take_trap ? ST_TRAP : ST_RUN;
            ST_TRAP: state_q <= trap_ack ? ST_RUN : ST_TRAP;
            default: state_q <= ST_RUN;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (take_trap) begin
        trap_pc <= m1_pc;  // faulting pc, held through the trap
    end
end

assert property (@(posedge clk) disable iff (!rst_n) trap_ack |-> state_q == ST_TRAP)
    else $error("trap_ack outside of trap state");

// the faulting op must be gone from stage one once the trap is taken
assert property (@(posedge clk) disable iff (!rst_n) state_q == ST_TRAP |-> !m1_misalign)
    else $error("misaligned access in stage one while trapped");

endmodule : mem_pipe_ctrl

`default_nettype wire

// ==== rtl/mem_stage1.sv ====
// memory stage one
// latches the op from execute, issues the data memory request,
// reports branches and misalignment, and forwards ALU/CSR results

`timescale 1ns/100ps
`default_nettype none

module mem_stage1
    import mem_pipe_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stall,
    input  wire logic                 m1_flush,
    input  wire logic                 m2_flush,
    input  wire logic                 e_valid,
    input  wire logic [XLEN-1:0]      e_pc,
    input  wire logic [XLEN-1:0]      e_alu_result,
    input  wire logic [XLEN-1:0]      e_rs2_val,
    input  wire logic [XLEN-1:0]      e_csr_old_val,
    input  wire logic [REG_IDX_W-1:0] e_rd_idx,
    input  wire logic                 e_rd_we,
    input  wire rd_src_e              e_rd_src,
    input  wire mem_op_e              e_mem_op,
    input  wire mem_size_e            e_mem_size,
    input  wire logic                 e_mem_signed,
    input  wire logic                 e_branch_taken,
    output logic [DMEM_AW-1:0]        mem_addr,
    output logic [DMEM_AW-1:0]        mem_waddr,
    output logic                      mem_re,
    output logic                      mem_we,
    output logic [BE_W-1:0]           mem_be,
    output logic [XLEN-1:0]           mem_wdata,
    output logic                      m1_valid,
    output logic [XLEN-1:0]           m1_pc,
    output logic [XLEN-1:0]           m1_alu_result,
    output logic [XLEN-1:0]           m1_csr_old_val,
    output logic [REG_IDX_W-1:0]      m1_rd_idx,
    output logic                      m1_rd_we,
    output rd_src_e                   m1_rd_src,
    output mem_op_e                   m1_mem_op,
    output mem_size_e                 m1_mem_size,
    output logic                      m1_mem_signed,
    output logic                      m1_branch,
    output logic                      m1_misalign,
    output logic [XLEN-1:0]           branch_target,
    output logic                      fwd1_we,
    output logic [REG_IDX_W-1:0]      fwd1_idx,
    output logic [XLEN-1:0]           fwd1_val,
    output logic                      fwd1_avail
);

logic            valid_q;
logic [XLEN-1:0] rs2_q;
logic            branch_q;
logic            misaligned;

always_ff @(posedge clk) begin
    if (!rst_n || m1_flush) begin
        valid_q <= 1'b0;
    end else if (!stall) begin
        valid_q <= e_valid;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        m1_pc          <= e_pc;
        m1_alu_result  <= e_alu_result;
        m1_csr_old_val <= e_csr_old_val;
        m1_rd_idx      <= e_rd_idx;
        m1_rd_we       <= e_rd_we;
        m1_rd_src      <= e_rd_src;
        m1_mem_op      <= e_mem_op;
        m1_mem_size    <= e_mem_size;
        m1_mem_signed  <= e_mem_signed;
        rs2_q          <= e_rs2_val;
        branch_q       <= e_branch_taken;
    end
end

assign m1_valid = valid_q && !m2_flush;

// load address comes straight from execute so the read lands with the op
assign mem_addr  = e_alu_result[DMEM_AW+1:2];
assign mem_re    = e_valid && !stall && (e_mem_op == MEM_LOAD);
assign mem_waddr = m1_alu_result[DMEM_AW+1:2];
assign mem_we    = m1_valid && !stall && (m1_mem_op == MEM_STORE);

always_comb begin
    unique case (m1_mem_size)
        SIZE_BYTE: begin
            mem_be     = BE_W'(1) << m1_alu_result[1:0];
            mem_wdata  = {(XLEN/8){rs2_q[7:0]}};   // replicate into every lane
            misaligned = 1'b0;
        end
        SIZE_HALF: begin
            mem_be     = BE_W'(3) << {m1_alu_result[1], 1'b0};
            mem_wdata  = {(XLEN/16){rs2_q[15:0]}};
            misaligned = m1_alu_result[0];
        end
        default: begin
            mem_be     = '1;
            mem_wdata  = rs2_q;
            misaligned = |m1_alu_result[1:0];
        end
    endcase
end

assign m1_misalign   = valid_q && (m1_mem_op != MEM_NONE) && misaligned;
assign m1_branch     = valid_q && branch_q;
assign branch_target = m1_alu_result;

// load data is not here yet, so loads report not available
assign fwd1_we    = valid_q && m1_rd_we;
assign fwd1_idx   = m1_rd_idx;
assign fwd1_avail = (m1_rd_src != RD_SRC_MEM);
assign fwd1_val   = (m1_rd_src == RD_SRC_CSR) ? m1_csr_old_val : m1_alu_result;

assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> (mem_be != '0) && !m1_misalign)
    else $error("store request without byte enables or misaligned");

endmodule : mem_stage1

`default_nettype wire

// ==== rtl/mem_stage2.sv ====
// memory stage two
// extracts and extends load data, picks the writeback value
// and forwards it, always available

`timescale 1ns/100ps
`default_nettype none

module mem_stage2
    import mem_pipe_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stall,
    input  wire logic                 m2_flush,
    input  wire logic                 m1_valid,
    input  wire logic [XLEN-1:0]      m1_alu_result,
    input  wire logic [XLEN-1:0]      m1_csr_old_val,
    input  wire logic [REG_IDX_W-1:0] m1_rd_idx,
    input  wire logic                 m1_rd_we,
    input  wire rd_src_e              m1_rd_src,
    input  wire mem_op_e              m1_mem_op,
    input  wire mem_size_e            m1_mem_size,
    input  wire logic                 m1_mem_signed,
    input  wire logic [XLEN-1:0]      mem_rdata,
    output logic                      wb_valid,
    output logic [REG_IDX_W-1:0]      wb_rd_idx,
    output logic                      wb_rd_we,
    output logic [XLEN-1:0]           wb_data,
    output logic                      fwd2_we,
    output logic [REG_IDX_W-1:0]      fwd2_idx,
    output logic [XLEN-1:0]           fwd2_val
);

logic [XLEN-1:0] alu_q;
logic [XLEN-1:0] csr_q;
logic [XLEN-1:0] rdata_q;
rd_src_e         rd_src_q;
mem_size_e       size_q;
logic            signed_q;
logic [7:0]      byte_sel;
logic [15:0]     half_sel;
logic [XLEN-1:0] load_val;

// a flush while stalled still has to empty this stage
always_ff @(posedge clk) begin
    if (!rst_n) begin
        wb_valid <= 1'b0;
    end else if (!stall) begin
        wb_valid <= m1_valid;
    end else if (m2_flush) begin
        wb_valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        alu_q     <= m1_alu_result;
        csr_q     <= m1_csr_old_val;
        wb_rd_idx <= m1_rd_idx;
        wb_rd_we  <= m1_rd_we;
        rd_src_q  <= m1_rd_src;
        size_q    <= m1_mem_size;
        signed_q  <= m1_mem_signed;
        if (m1_mem_op == MEM_LOAD) begin
            rdata_q <= mem_rdata;  // read word only matters for loads
        end
    end
end

assign byte_sel = rdata_q[{alu_q[1:0], 3'b000} +: 8];
assign half_sel = alu_q[1] ? rdata_q[31:16] : rdata_q[15:0];

always_comb begin
    unique case (size_q)
        SIZE_BYTE: load_val = {{(XLEN-8){signed_q & byte_sel[7]}}, byte_sel};
        SIZE_HALF: load_val = {{(XLEN-16){signed_q & half_sel[15]}}, half_sel};
        default:   load_val = rdata_q;
    endcase
end

always_comb begin
    unique case (rd_src_q)
        RD_SRC_CSR: wb_data = csr_q;
        RD_SRC_MEM: wb_data = load_val;
        default:    wb_data = alu_q;
    endcase
end

assign fwd2_we  = wb_valid && wb_rd_we;
assign fwd2_idx = wb_rd_idx;
assign fwd2_val = wb_data;

endmodule : mem_stage2

`default_nettype wire

// ==== rtl/data_mem.sv ====
// data memory
// word-wide synchronous RAM with byte enables; a read of the word
// being written on the same edge returns the merged new data

`timescale 1ns/100ps
`default_nettype none

module data_mem
    import mem_pipe_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               stall,
    input  wire logic [DMEM_AW-1:0] mem_addr,
    input  wire logic [DMEM_AW-1:0] mem_waddr,
    input  wire logic               mem_re,
    input  wire logic               mem_we,
    input  wire logic [BE_W-1:0]    mem_be,
    input  wire logic [XLEN-1:0]    mem_wdata,
    output logic [XLEN-1:0]         mem_rdata
);

logic [XLEN-1:0] ram [DMEM_WORDS];
logic [XLEN-1:0] merged;  // store lanes laid over the old word
logic            bypass;

always_comb begin
    for (int i = 0; i < BE_W; i++) begin
        merged[8*i +: 8] = mem_be[i] ? mem_wdata[8*i +: 8] : ram[mem_waddr][8*i +: 8];
    end
end

assign bypass = mem_we && (mem_waddr == mem_addr);

always_ff @(posedge clk) begin
    for (int i = 0; i < BE_W; i++) begin
        if (mem_we && mem_be[i]) begin
            ram[mem_waddr][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
    end
end

// read word held while stalled, the load waits in stage one
always_ff @(posedge clk) begin
    if (mem_re && !stall) begin
        mem_rdata <= bypass ? merged : ram[mem_addr];
    end
end

endmodule : data_mem

`default_nettype wire

// ==== rtl/mem_pipe_top.sv ====
// memory pipeline top
// control, both memory stages and the data RAM

`timescale 1ns/100ps
`default_nettype none

module mem_pipe_top
    import mem_pipe_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 e_valid,
    input  wire logic [XLEN-1:0]      e_pc,
    input  wire logic [XLEN-1:0]      e_alu_result,
    input  wire logic [XLEN-1:0]      e_rs2_val,
    input  wire logic [XLEN-1:0]      e_csr_old_val,
    input  wire logic [REG_IDX_W-1:0] e_rd_idx,
    input  wire logic                 e_rd_we,
    input  wire rd_src_e              e_rd_src,
    input  wire mem_op_e              e_mem_op,
    input  wire mem_size_e            e_mem_size,
    input  wire logic                 e_mem_signed,
    input  wire logic                 e_branch_taken,
    input  wire logic                 wb_stall,
    input  wire logic                 flush,
    input  wire logic                 trap_ack,
    output logic                      ready,
    output logic                      wb_valid,
    output logic [REG_IDX_W-1:0]      wb_rd_idx,
    output logic                      wb_rd_we,
    output logic [XLEN-1:0]           wb_data,
    output logic                      branch_taken,
    output logic [XLEN-1:0]           branch_target,
    output logic                      trap,
    output logic [XLEN-1:0]           trap_pc,
    output logic                      fwd1_we,
    output logic [REG_IDX_W-1:0]      fwd1_idx,
    output logic [XLEN-1:0]           fwd1_val,
    output logic                      fwd1_avail,
    output logic                      fwd2_we,
    output logic [REG_IDX_W-1:0]      fwd2_idx,
    output logic [XLEN-1:0]           fwd2_val
);

logic                 stall;
logic                 m1_flush;
logic                 m2_flush;
logic                 m1_misalign;
logic [DMEM_AW-1:0]   mem_addr;
logic [DMEM_AW-1:0]   mem_waddr;
logic                 mem_re;
logic                 mem_we;
logic [BE_W-1:0]      mem_be;
logic [XLEN-1:0]      mem_wdata;
logic [XLEN-1:0]      mem_rdata;
logic                 m1_valid;
logic [XLEN-1:0]      m1_pc;
logic [XLEN-1:0]      m1_alu_result;
logic [XLEN-1:0]      m1_csr_old_val;
logic [REG_IDX_W-1:0] m1_rd_idx;
logic                 m1_rd_we;
rd_src_e              m1_rd_src;
mem_op_e              m1_mem_op;
mem_size_e            m1_mem_size;
logic                 m1_mem_signed;

mem_pipe_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_stall    (wb_stall),
    .flush       (flush),
    .trap_ack    (trap_ack),
    .m1_branch   (branch_taken),
    .m1_misalign (m1_misalign),
    .m1_pc       (m1_pc),
    .stall       (stall),
    .m1_flush    (m1_flush),
    .m2_flush    (m2_flush),
    .ready       (ready),
    .trap        (trap),
    .trap_pc     (trap_pc)
);

mem_stage1 i_stage1 (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .m1_flush       (m1_flush),
    .m2_flush       (m2_flush),
    .e_valid        (e_valid),
    .e_pc           (e_pc),
    .e_alu_result   (e_alu_result),
    .e_rs2_val      (e_rs2_val),
    .e_csr_old_val  (e_csr_old_val),
    .e_rd_idx       (e_rd_idx),
    .e_rd_we        (e_rd_we),
    .e_rd_src       (e_rd_src),
    .e_mem_op       (e_mem_op),
    .e_mem_size     (e_mem_size),
    .e_mem_signed   (e_mem_signed),
    .e_branch_taken (e_branch_taken),
    .mem_addr       (mem_addr),
    .mem_waddr      (mem_waddr),
    .mem_re         (mem_re),
    .mem_we         (mem_we),
    .mem_be         (mem_be),
    .mem_wdata      (mem_wdata),
    .m1_valid       (m1_valid),
    .m1_pc          (m1_pc),
    .m1_alu_result  (m1_alu_result),
    .m1_csr_old_val (m1_csr_old_val),
    .m1_rd_idx      (m1_rd_idx),
    .m1_rd_we       (m1_rd_we),
    .m1_rd_src      (m1_rd_src),
    .m1_mem_op      (m1_mem_op),
    .m1_mem_size    (m1_mem_size),
    .m1_mem_signed  (m1_mem_signed),
    .m1_branch      (branch_taken),
    .m1_misalign    (m1_misalign),
    .branch_target  (branch_target),
    .fwd1_we        (fwd1_we),
    .fwd1_idx       (fwd1_idx),
    .fwd1_val       (fwd1_val),
    .fwd1_avail     (fwd1_avail)
);

mem_stage2 i_stage2 (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .m2_flush       (m2_flush),
    .m1_valid       (m1_valid),
    .m1_alu_result  (m1_alu_result),
    .m1_csr_old_val (m1_csr_old_val),
    .m1_rd_idx      (m1_rd_idx),
    .m1_rd_we       (m1_rd_we),
    .m1_rd_src      (m1_rd_src),
    .m1_mem_op      (m1_mem_op),
    .m1_mem_size    (m1_mem_size),
    .m1_mem_signed  (m1_mem_signed),
    .mem_rdata      (mem_rdata),
    .wb_valid       (wb_valid),
    .wb_rd_idx      (wb_rd_idx),
    .wb_rd_we       (wb_rd_we),
    .wb_data        (wb_data),
    .fwd2_we        (fwd2_we),
    .fwd2_idx       (fwd2_idx),
    .fwd2_val       (fwd2_val)
);

data_mem i_dmem (
    .clk       (clk),
    .stall     (stall),
    .mem_addr  (mem_addr),
    .mem_waddr (mem_waddr),
    .mem_re    (mem_re),
    .mem_we    (mem_we),
    .mem_be    (mem_be),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
);

endmodule : mem_pipe_top

`default_nettype wire

// ==== tests/mem_pipe_tb.sv ====
// memory pipeline testbench
// applies a table of operations and checks writeback, forwarding,
// branch and trap outputs against a byte-level reference memory

`timescale 1ns/100ps
`default_nettype none

module mem_pipe_tb
    import mem_pipe_pkg::*;
();

localparam int MEM_BYTES    = DMEM_WORDS * 4;
localparam int STALL_CYCLES = 3;
localparam int ACK_DELAY    = 3;   // trap cycles before the ack is driven

typedef struct packed {
    mem_op_e              op;
    mem_size_e            size;
    logic                 sgn;
    logic [XLEN-1:0]      alu;     // alu result and access address
    logic [XLEN-1:0]      wdata;
    logic [XLEN-1:0]      csr;
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_we;
    rd_src_e              src;
    logic                 br;
    logic                 stl;     // wb_stall held while presented
    logic                 fl;      // flush on the accepting edge
    logic                 keep;    // expected to reach writeback
    logic [XLEN-1:0]      pc;
} row_t;

typedef struct packed {
    logic [REG_IDX_W-1:0] rd;
    logic                 we;
    logic [XLEN-1:0]      data;
} wb_t;

logic clk, rst_n, e_valid, e_rd_we, e_mem_signed, e_branch_taken;
logic [XLEN-1:0] e_pc, e_alu_result, e_rs2_val, e_csr_old_val;
logic [REG_IDX_W-1:0] e_rd_idx;
rd_src_e   e_rd_src;
mem_op_e   e_mem_op;
mem_size_e e_mem_size;
logic wb_stall, flush, trap_ack;
logic ready, wb_valid, wb_rd_we, branch_taken, trap, fwd1_we, fwd1_avail, fwd2_we;
logic [REG_IDX_W-1:0] wb_rd_idx, fwd1_idx, fwd2_idx;
logic [XLEN-1:0] wb_data, branch_target, trap_pc, fwd1_val, fwd2_val;

row_t            rows[$];
wb_t             exp_q[$];     // writebacks owed by stage two in age order
logic [7:0]      ref_mem [MEM_BYTES];
logic [XLEN-1:0] rng;
int              cycles;
int              limit;
row_t            cur;          // op on the inputs
row_t            s1;           // op the model holds in stage one
logic            cur_v, s1_v;
logic            trap_m, ack_q;
logic [XLEN-1:0] trap_pc_m;
int              trap_wait;

mem_pipe_top i_dut (.*);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

function automatic logic [XLEN-1:0] xorshift(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// little-endian read from the reference memory and then extension
function automatic logic [XLEN-1:0] load_value(input row_t r);
    int              a;
    logic [XLEN-1:0] w;
    a = int'(r.alu[9:0]);
    w = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    case (r.size)
        SIZE_BYTE: return r.sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
        SIZE_HALF: return r.sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
        default:   return w;
    endcase
endfunction

function automatic logic misaligned(input row_t r);
    if (r.op == MEM_NONE) return 1'b0;
    if (r.size == SIZE_HALF) return r.alu[0];
    if (r.size == SIZE_WORD) return r.alu[1:0] != 2'b00;
    return 1'b0;
endfunction

task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
endtask

task automatic check(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                     input string what);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic add_row(input mem_op_e op, input mem_size_e size, input logic sgn,
                       input logic [XLEN-1:0] alu, input logic [REG_IDX_W-1:0] rd,
                       input rd_src_e src, input logic br, input logic stl,
                       input logic fl, input logic keep);
    row_t r;
    rng = xorshift(rng);
    r.wdata = rng;                  // random store data
    rng = xorshift(rng);
    r.csr = rng;
    r.op = op;
    r.size = size;
    r.sgn = sgn;
    r.alu = alu;
    r.rd = rd;
    r.rd_we = (rd != 0);
    r.src = src;
    r.br = br;
    r.stl = stl;
    r.fl = fl;
    r.keep = keep;
    r.pc = 32'h1000 + 4 * rows.size();
    rows.push_back(r);
endtask

task automatic drop(input row_t r);
    check(r.keep, 1'b0, $sformatf("survival of op at pc %h", r.pc));
endtask

// stores hit the reference memory and a writeback is owed as an op leaves stage one
task automatic retire(input row_t r);
    wb_t w;
    int  n;
    int  i;
    check(r.keep, 1'b1, $sformatf("survival of op at pc %h", r.pc));
    w.rd = r.rd;
    w.we = r.rd_we;
    case (r.src)
        RD_SRC_CSR: w.data = r.csr;
        RD_SRC_MEM: w.data = load_value(r);
        default:    w.data = r.alu;
    endcase
    if (r.op == MEM_STORE) begin
        n = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
        for (i = 0; i < n; i++) begin
            ref_mem[int'(r.alu[9:0]) + i] = r.wdata[8*i +: 8];
        end
    end
    exp_q.push_back(w);
endtask

task automatic present(input row_t r);
    e_valid        <= 1'b1;
    e_pc           <= r.pc;
    e_alu_result   <= r.alu;
    e_rs2_val      <= r.wdata;
    e_csr_old_val  <= r.csr;
    e_rd_idx       <= r.rd;
    e_rd_we        <= r.rd_we;
    e_rd_src       <= r.src;
    e_mem_op       <= r.op;
    e_mem_size     <= r.size;
    e_mem_signed   <= r.sgn;
    e_branch_taken <= r.br;
    flush          <= r.fl;
endtask

// check the pre-edge outputs at one clock edge and then advance the model
task automatic step(output logic took);
    logic stall_m;
    logic squash;
    wb_t  w;
    @(posedge clk);
    cycles++;
    if (cycles > limit) begin
        abort_run($sformatf("timeout: pipeline still busy after %0d cycles", limit));
    end
    stall_m = wb_stall || trap_m;
    check(ready, !stall_m, "ready");
    check(trap, trap_m, "trap");
    if (trap_m) check(trap_pc, trap_pc_m, "trap_pc");
    check(wb_valid, exp_q.size() != 0, "wb_valid");
    if (wb_valid && !stall_m) begin   // consumed at this edge
        w = exp_q.pop_front();
        check(wb_rd_idx, w.rd, "wb_rd_idx");
        check(wb_rd_we, w.we, "wb_rd_we");
        check(fwd2_we, w.we, "fwd2_we");
        check(fwd2_idx, w.rd, "fwd2_idx");
        if (w.we) begin
            check(wb_data, w.data, "wb_data");
            check(fwd2_val, w.data, "fwd2_val");
        end
    end
    check(branch_taken, s1_v && s1.br, "branch_taken");
    if (s1_v && s1.br) check(branch_target, s1.alu, "branch_target");
    check(fwd1_we, s1_v && s1.rd_we, "fwd1_we");
    if (s1_v && s1.rd_we) begin
        check(fwd1_idx, s1.rd, "fwd1_idx");
        check(fwd1_avail, s1.src != RD_SRC_MEM, "fwd1_avail");
        if (s1.src != RD_SRC_MEM) begin
            check(fwd1_val, (s1.src == RD_SRC_CSR) ? s1.csr : s1.alu, "fwd1_val");
        end
    end

    took = cur_v && !stall_m;
    if (trap_m && ack_q) trap_m = 1'b0;
    if (flush) begin
        if (s1_v) drop(s1);
        if (took) drop(cur);
        s1_v = 1'b0;
    end else if (!stall_m) begin
        squash = 1'b0;
        if (s1_v && misaligned(s1)) begin
            drop(s1);
            trap_m = 1'b1;
            trap_pc_m = s1.pc;
            trap_wait = 0;
            squash = 1'b1;
        end else if (s1_v) begin
            retire(s1);
            squash = s1.br;           // wrong-path op behind a taken branch
        end
        if (took && squash) drop(cur);
        s1 = cur;
        s1_v = took && !squash;
    end
    if (trap_m) trap_wait++;
    ack_q = trap_m && (trap_wait == ACK_DELAY);
    trap_ack <= ack_q;
endtask

initial begin
    logic took;
    int   stall_left;
    rst_n = 1'b0;
    e_valid = 1'b0;
    e_pc = '0;
    e_alu_result = '0;
    e_rs2_val = '0;
    e_csr_old_val = '0;
    e_rd_idx = '0;
    e_rd_we = 1'b0;
    e_rd_src = RD_SRC_ALU;
    e_mem_op = MEM_NONE;
    e_mem_size = SIZE_WORD;
    e_mem_signed = 1'b0;
    e_branch_taken = 1'b0;
    wb_stall = 1'b0;
    flush = 1'b0;
    trap_ack = 1'b0;
    rng = 32'ha8db1636;
    cycles = 0;
    cur_v = 1'b0;
    s1_v = 1'b0;
    trap_m = 1'b0;
    ack_q = 1'b0;
    trap_wait = 0;

    // op, size, signed, alu/address, rd, source, branch, stall, flush, keep
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h100, 0, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h104, 0, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h108, 0, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_STORE, SIZE_BYTE, 0, 32'h101, 0, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_STORE, SIZE_HALF, 0, 32'h106, 0, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h104, 1, RD_SRC_MEM, 0, 0, 0, 1);  // behind its store
    add_row(MEM_LOAD,  SIZE_BYTE, 1, 32'h101, 2, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_BYTE, 0, 32'h101, 3, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_HALF, 1, 32'h102, 4, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_HALF, 0, 32'h106, 5, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h100, 6, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_BYTE, 1, 32'h10b, 7, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h1234_5678, 8, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h0, 9, RD_SRC_CSR, 0, 0, 0, 1);
    // the store accepted with the taken branch must vanish
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h2000, 0, RD_SRC_ALU, 1, 0, 0, 1);
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h100, 0, RD_SRC_ALU, 0, 0, 0, 0);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h100, 10, RD_SRC_MEM, 0, 0, 0, 1);
    // misaligned half store traps; the op accepted behind it is squashed
    add_row(MEM_STORE, SIZE_HALF, 0, 32'h10b, 0, RD_SRC_ALU, 0, 0, 0, 0);
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h104, 0, RD_SRC_ALU, 0, 0, 0, 0);
    add_row(MEM_LOAD,  SIZE_HALF, 0, 32'h10a, 11, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h104, 12, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h0bad_f00d, 13, RD_SRC_ALU, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h0, 14, RD_SRC_CSR, 0, 1, 0, 1);
    add_row(MEM_LOAD,  SIZE_BYTE, 1, 32'h107, 15, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h7f00_0001, 16, RD_SRC_ALU, 0, 1, 0, 1);
    // flush drops the store in stage one and the one accepted with it
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h100, 0, RD_SRC_ALU, 0, 0, 0, 0);
    add_row(MEM_STORE, SIZE_WORD, 0, 32'h104, 0, RD_SRC_ALU, 0, 0, 1, 0);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h100, 17, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_LOAD,  SIZE_WORD, 0, 32'h104, 18, RD_SRC_MEM, 0, 0, 0, 1);
    add_row(MEM_NONE,  SIZE_WORD, 0, 32'h5555_aaaa, 19, RD_SRC_ALU, 0, 0, 0, 1);
    limit = 4 * rows.size() + 50;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (rows[i]) begin
        cur = rows[i];
        cur_v = 1'b1;
        present(rows[i]);
        stall_left = rows[i].stl ? STALL_CYCLES : 0;
        wb_stall <= (stall_left > 0);
        took = 1'b0;
        while (!took) begin
            step(took);
            if (stall_left > 0) stall_left--;
            wb_stall <= (stall_left > 0);
        end
    end

    cur_v = 1'b0;
    e_valid <= 1'b0;
    flush <= 1'b0;
    while (s1_v || exp_q.size() != 0) step(took);
    repeat (3) step(took);    // nothing extra may come out
    $display("=== PASS ===");
    $finish;
end

endmodule : mem_pipe_tb

`default_nettype wire

// ==== flist.f ====
rtl/mem_pipe_pkg.sv
rtl/mem_pipe_ctrl.sv
rtl/mem_stage1.sv
rtl/mem_stage2.sv
rtl/data_mem.sv
rtl/mem_pipe_top.sv
tests/mem_pipe_tb.sv
